// File: cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 16;
    localparam int OFFSET_W   = 4;                          // byte offset in a line
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - OFFSET_W - INDEX_W;
    localparam int WB_DEPTH   = 4;
    localparam int WOFF_W     = OFFSET_W - 2;               // word offset in a line
    localparam int STRB_W     = DATA_W / 8;
    localparam int LEN_W      = 4;                          // arlen width
    localparam int WB_PTR_W   = $clog2(WB_DEPTH);

    // size codes from the core
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_INVAL
    } mem_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        DRAIN_WB,
        REFILL,
        RESPOND
    } cache_state_e;

    typedef struct packed {
        mem_op_e           op;
        logic              cached;
        logic [ADDR_W-1:0] addr;
        logic [1:0]        size;
        logic [DATA_W-1:0] wdata;
    } core_req_t;

    typedef struct packed {
        mem_op_e            op;
        logic               cached;
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [WOFF_W-1:0]  woff;
        logic [STRB_W-1:0]  strb;
        logic [DATA_W-1:0]  wdata;      // already in its byte lanes
    } cache_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } core_resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;        // word aligned
        logic [LEN_W-1:0]  len;         // beats minus one
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_W-3:0] waddr;       // word address
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wb_entry_t;

    typedef struct packed {
        logic [ADDR_W-1:0] araddr;
        logic [LEN_W-1:0]  arlen;
        logic              arvalid;
        logic              rready;
    } axi_rd_req_t;

    typedef struct packed {
        logic              arready;
        logic [DATA_W-1:0] rdata;
        logic              rlast;
        logic              rvalid;
    } axi_rd_resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              wlast;
        logic              wvalid;
        logic              bready;
    } axi_wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } axi_wr_resp_t;

endpackage

// File: core_req_port.sv
`timescale 1ns/1ps
module core_req_port (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  cache_pkg::core_req_t  i_req,
    input  logic                  i_req_valid,
    output logic                  o_req_ready,
    output cache_pkg::cache_req_t o_creq,
    output logic                  o_creq_valid,
    input  logic                  i_creq_done
);
    import cache_pkg::*;

    logic [STRB_W-1:0] w_strb;
    logic [DATA_W-1:0] w_wdata;
    logic              w_accept;

    assign w_accept = i_req_valid && o_req_ready;

    // strobes and lane replication from size and low address bits
    always_comb begin
        case (i_req.size)
            SIZE_BYTE: begin
                w_strb  = STRB_W'(1) << i_req.addr[1:0];
                w_wdata = {STRB_W{i_req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                w_strb  = STRB_W'(3) << {i_req.addr[1], 1'b0};
                w_wdata = {(STRB_W/2){i_req.wdata[15:0]}};
            end
            SIZE_WORD: begin
                w_strb  = '1;
                w_wdata = i_req.wdata;
            end
            default: begin
                w_strb  = '0;             // reserved size writes nothing
                w_wdata = i_req.wdata;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_creq_valid <= 1'b0;
            o_req_ready  <= 1'b0;
        end else if (w_accept) begin
            o_creq_valid <= 1'b1;
            o_req_ready  <= 1'b0;         // one request in flight
        end else if (i_creq_done) begin
            o_creq_valid <= 1'b0;
            o_req_ready  <= 1'b1;
        end else begin
            o_req_ready <= !o_creq_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            o_creq.op     <= i_req.op;
            o_creq.cached <= i_req.cached;
            o_creq.tag    <= i_req.addr[ADDR_W-1 -: TAG_W];
            o_creq.index  <= i_req.addr[OFFSET_W +: INDEX_W];
            o_creq.woff   <= i_req.addr[2 +: WOFF_W];
            o_creq.strb   <= w_strb;
            o_creq.wdata  <= w_wdata;
        end
    end

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps
module dcache_ctrl (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  cache_pkg::cache_req_t            i_creq,
    input  logic                             i_creq_valid,
    output logic                             o_creq_done,
    output cache_pkg::core_resp_t            o_resp,
    output logic                             o_resp_valid,
    output cache_pkg::rd_req_t               o_rd_req,
    output logic                             o_rd_req_valid,
    input  logic                             i_rd_req_ready,
    input  logic [cache_pkg::DATA_W-1:0]     i_fill_data,
    input  logic [cache_pkg::WOFF_W-1:0]     i_fill_beat,
    input  logic                             i_fill_valid,
    input  logic                             i_fill_done,
    output cache_pkg::wb_entry_t             o_wb_entry,
    output logic                             o_wb_valid,
    input  logic                             i_wb_ready,
    input  logic                             i_wb_empty,
    output logic                             o_busy
);
    import cache_pkg::*;

    cache_state_e r_state;
    cache_state_e w_next;

    logic [TAG_W-1:0]     r_tag  [NUM_LINES];
    logic [NUM_LINES-1:0] r_valid;
    logic [DATA_W-1:0]    r_data [NUM_LINES*LINE_WORDS];
    logic [DATA_W-1:0]    r_rdata;        // word picked off the refill
    logic                 r_wb_stall;     // store found the buffer full

    logic                      w_hit;
    logic                      w_push;
    logic [INDEX_W+WOFF_W-1:0] w_word_idx;
    logic [INDEX_W+WOFF_W-1:0] w_fill_idx;
    logic [WOFF_W-1:0]         w_want_beat;

    assign w_hit = i_creq.cached && r_valid[i_creq.index]
                   && (r_tag[i_creq.index] == i_creq.tag);
    assign w_word_idx  = {i_creq.index, i_creq.woff};
    assign w_fill_idx  = {i_creq.index, i_fill_beat};
    assign w_want_beat = i_creq.cached ? i_creq.woff : '0;   // uncached is one beat
    assign o_busy      = r_state != IDLE;

    // write-through push, hit or miss
    assign o_wb_valid       = (r_state == LOOKUP) && (i_creq.op == OP_WRITE);
    assign w_push           = o_wb_valid && i_wb_ready;
    assign o_wb_entry.waddr = {i_creq.tag, i_creq.index, i_creq.woff};
    assign o_wb_entry.data  = i_creq.wdata;
    assign o_wb_entry.strb  = i_creq.strb;

    // line burst when cached, single word otherwise
    assign o_rd_req_valid = (r_state == DRAIN_WB) && i_wb_empty;
    assign o_rd_req.addr  = {i_creq.tag, i_creq.index,
                             i_creq.cached ? WOFF_W'(0) : i_creq.woff, 2'b00};
    assign o_rd_req.len   = i_creq.cached ? LEN_W'(LINE_WORDS - 1) : '0;

    assign o_resp.rdata = (i_creq.op != OP_READ) ? '0 :
                          (r_state == RESPOND) ? r_rdata : r_data[w_word_idx];
    assign o_creq_done  = o_resp_valid;

    always_comb begin
        w_next       = r_state;
        o_resp_valid = 1'b0;
        case (r_state)
            IDLE: begin
                if (i_creq_valid) begin
                    w_next = LOOKUP;
                end
            end
            LOOKUP: begin
                case (i_creq.op)
                    OP_READ: begin
                        if (w_hit) begin
                            o_resp_valid = 1'b1;
                            w_next       = IDLE;
                        end else begin
                            w_next = DRAIN_WB;   // keep reads behind posted stores
                        end
                    end
                    OP_WRITE: begin
                        if (w_push && r_wb_stall) begin
                            w_next = RESPOND;
                        end else if (w_push) begin
                            o_resp_valid = 1'b1;
                            w_next       = IDLE;
                        end
                    end
                    default: begin
                        o_resp_valid = 1'b1;
                        w_next       = IDLE;
                    end
                endcase
            end
            DRAIN_WB: begin
                if (o_rd_req_valid && i_rd_req_ready) begin
                    w_next = REFILL;
                end
            end
            REFILL: begin
                if (i_fill_done) begin
                    w_next = RESPOND;
                end
            end
            RESPOND: begin
                o_resp_valid = 1'b1;
                w_next       = IDLE;
            end
            default: w_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state    <= IDLE;
            r_valid    <= '0;
            r_wb_stall <= 1'b0;
        end else begin
            r_state    <= w_next;
            r_wb_stall <= o_wb_valid && !i_wb_ready;
            if (r_state == LOOKUP && i_creq.op == OP_INVAL) begin
                r_valid[i_creq.index] <= 1'b0;
            end
            if (i_fill_done && i_creq.cached) begin
                r_valid[i_creq.index] <= 1'b1;   // allocate on read miss only
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push && w_hit) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_creq.strb[b]) begin
                    r_data[w_word_idx][8*b +: 8] <= i_creq.wdata[8*b +: 8];
                end
            end
        end
        if (i_fill_valid) begin
            if (i_creq.cached) begin
                r_data[w_fill_idx] <= i_fill_data;
            end
            if (i_fill_beat == w_want_beat) begin
                r_rdata <= i_fill_data;
            end
        end
        if (i_fill_done && i_creq.cached) begin
            r_tag[i_creq.index] <= i_creq.tag;
        end
    end

endmodule

// File: refill_engine.sv
`timescale 1ns/1ps
module refill_engine (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  cache_pkg::rd_req_t           i_rd_req,
    input  logic                         i_rd_req_valid,
    output logic                         o_rd_req_ready,
    output logic [cache_pkg::DATA_W-1:0] o_fill_data,
    output logic [cache_pkg::WOFF_W-1:0] o_fill_beat,
    output logic                         o_fill_valid,
    output logic                         o_fill_done,
    output cache_pkg::axi_rd_req_t       o_axi_rd,
    input  cache_pkg::axi_rd_resp_t      i_axi_rd
);
    import cache_pkg::*;

    logic              r_arvalid;
    logic              r_rwait;       // AR accepted, R beats pending
    logic [ADDR_W-1:0] r_araddr;
    logic [LEN_W-1:0]  r_arlen;
    logic [WOFF_W-1:0] r_beat;
    logic              w_accept;

    assign o_rd_req_ready = !r_arvalid && !r_rwait;
    assign w_accept       = i_rd_req_valid && o_rd_req_ready;

    assign o_axi_rd.araddr  = r_araddr;
    assign o_axi_rd.arlen   = r_arlen;
    assign o_axi_rd.arvalid = r_arvalid;
    assign o_axi_rd.rready  = r_rwait;

    // beats go straight through to the controller
    assign o_fill_valid = r_rwait && i_axi_rd.rvalid;
    assign o_fill_data  = i_axi_rd.rdata;
    assign o_fill_beat  = r_beat;
    assign o_fill_done  = o_fill_valid && i_axi_rd.rlast;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_arvalid <= 1'b0;
            r_rwait   <= 1'b0;
        end else begin
            if (w_accept) begin
                r_arvalid <= 1'b1;
            end
            if (r_arvalid && i_axi_rd.arready) begin
                r_arvalid <= 1'b0;
                r_rwait   <= 1'b1;
            end
            if (o_fill_done) begin
                r_rwait <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_araddr <= i_rd_req.addr;
            r_arlen  <= i_rd_req.len;
            r_beat   <= '0;
        end else if (o_fill_valid) begin
            r_beat <= r_beat + 1'b1;
        end
    end

endmodule

// File: write_buffer.sv
`timescale 1ns/1ps
module write_buffer (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  cache_pkg::wb_entry_t    i_entry,
    input  logic                    i_entry_valid,
    output logic                    o_entry_ready,
    output logic                    o_empty,
    output cache_pkg::axi_wr_req_t  o_axi_wr,
    input  cache_pkg::axi_wr_resp_t i_axi_wr
);
    import cache_pkg::*;

    wb_entry_t           r_mem [WB_DEPTH];
    logic [WB_PTR_W-1:0] r_wr_ptr;
    logic [WB_PTR_W-1:0] r_rd_ptr;
    logic [WB_PTR_W:0]   r_count;
    logic                r_aw_done;     // head address accepted
    logic                r_w_done;      // head data accepted
    logic                w_push;
    logic                w_pop;
    wb_entry_t           w_head;

    assign w_head        = r_mem[r_rd_ptr];
    assign o_empty       = r_count == '0;
    assign o_entry_ready = r_count != (WB_PTR_W+1)'(WB_DEPTH);
    assign w_push        = i_entry_valid && o_entry_ready;
    assign w_pop         = o_axi_wr.bready && i_axi_wr.bvalid;

    // head entry as one single-beat write
    assign o_axi_wr.awaddr  = {w_head.waddr, 2'b00};
    assign o_axi_wr.awvalid = !o_empty && !r_aw_done;
    assign o_axi_wr.wdata   = w_head.data;
    assign o_axi_wr.wstrb   = w_head.strb;
    assign o_axi_wr.wlast   = 1'b1;
    assign o_axi_wr.wvalid  = !o_empty && !r_w_done;
    assign o_axi_wr.bready  = r_aw_done && r_w_done;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wr_ptr  <= '0;
            r_rd_ptr  <= '0;
            r_count   <= '0;
            r_aw_done <= 1'b0;
            r_w_done  <= 1'b0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr  <= r_rd_ptr + 1'b1;
                r_aw_done <= 1'b0;
                r_w_done  <= 1'b0;
            end else begin
                if (o_axi_wr.awvalid && i_axi_wr.awready) begin
                    r_aw_done <= 1'b1;
                end
                if (o_axi_wr.wvalid && i_axi_wr.wready) begin
                    r_w_done <= 1'b1;
                end
            end
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_entry;
        end
    end

endmodule

// File: cache_soc.sv
`timescale 1ns/1ps
module cache_soc (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  cache_pkg::core_req_t    i_req,
    input  logic                    i_req_valid,
    output logic                    o_req_ready,
    output cache_pkg::core_resp_t   o_resp,
    output logic                    o_resp_valid,
    output logic                    o_idle,
    output cache_pkg::axi_rd_req_t  o_axi_rd,
    input  cache_pkg::axi_rd_resp_t i_axi_rd,
    output cache_pkg::axi_wr_req_t  o_axi_wr,
    input  cache_pkg::axi_wr_resp_t i_axi_wr
);
    import cache_pkg::*;

    cache_req_t        w_creq;
    logic              w_creq_valid;
    logic              w_creq_done;
    rd_req_t           w_rd_req;
    logic              w_rd_req_valid;
    logic              w_rd_req_ready;
    logic [DATA_W-1:0] w_fill_data;
    logic [WOFF_W-1:0] w_fill_beat;
    logic              w_fill_valid;
    logic              w_fill_done;
    wb_entry_t         w_wb_entry;
    logic              w_wb_valid;
    logic              w_wb_ready;
    logic              w_wb_empty;
    logic              w_busy;

    // refill engine is idle when it can take a command
    assign o_idle = !w_busy && w_rd_req_ready && w_wb_empty;

    core_req_port u_port (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .o_creq       (w_creq),
        .o_creq_valid (w_creq_valid),
        .i_creq_done  (w_creq_done)
    );

    dcache_ctrl u_dcache (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_creq         (w_creq),
        .i_creq_valid   (w_creq_valid),
        .o_creq_done    (w_creq_done),
        .o_resp         (o_resp),
        .o_resp_valid   (o_resp_valid),
        .o_rd_req       (w_rd_req),
        .o_rd_req_valid (w_rd_req_valid),
        .i_rd_req_ready (w_rd_req_ready),
        .i_fill_data    (w_fill_data),
        .i_fill_beat    (w_fill_beat),
        .i_fill_valid   (w_fill_valid),
        .i_fill_done    (w_fill_done),
        .o_wb_entry     (w_wb_entry),
        .o_wb_valid     (w_wb_valid),
        .i_wb_ready     (w_wb_ready),
        .i_wb_empty     (w_wb_empty),
        .o_busy         (w_busy)
    );

    refill_engine u_refill (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rd_req       (w_rd_req),
        .i_rd_req_valid (w_rd_req_valid),
        .o_rd_req_ready (w_rd_req_ready),
        .o_fill_data    (w_fill_data),
        .o_fill_beat    (w_fill_beat),
        .o_fill_valid   (w_fill_valid),
        .o_fill_done    (w_fill_done),
        .o_axi_rd       (o_axi_rd),
        .i_axi_rd       (i_axi_rd)
    );

    write_buffer u_wbuf (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_entry       (w_wb_entry),
        .i_entry_valid (w_wb_valid),
        .o_entry_ready (w_wb_ready),
        .o_empty       (w_wb_empty),
        .o_axi_wr      (o_axi_wr),
        .i_axi_wr      (i_axi_wr)
    );

endmodule

// File: axi_mem_model.sv
`timescale 1ns/1ps
module axi_mem_model (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  cache_pkg::axi_rd_req_t  i_rd,
    output cache_pkg::axi_rd_resp_t o_rd,
    input  cache_pkg::axi_wr_req_t  i_wr,
    output cache_pkg::axi_wr_resp_t o_wr
);
    import cache_pkg::*;

    logic [DATA_W-1:0] mem [logic [ADDR_W-3:0]];   // sparse, only written words stored
    integer            seed;
    logic              rd_active;
    logic [ADDR_W-1:0] rd_addr;
    logic [LEN_W-1:0]  rd_len;
    logic [LEN_W-1:0]  rd_beat;
    logic              aw_got;
    logic              w_got;
    logic [ADDR_W-1:0] aw_addr;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    logic [DATA_W-1:0] merged;

    initial seed = 32'hc9e7da2d;

    // unwritten words hold the address fill pattern
    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-3:0] wa);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return {wa, 2'b00} ^ 32'h5a5a_0000;
    endfunction

    always @(posedge i_clk) begin
        if (i_rst) begin
            o_rd      <= '0;
            o_wr      <= '0;
            rd_active <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
        end else begin
            if (!rd_active) begin
                o_rd.arready <= ($random(seed) & 3) != 0;
                if (i_rd.arvalid && o_rd.arready) begin
                    o_rd.arready <= 1'b0;
                    rd_active    <= 1'b1;
                    rd_addr      <= i_rd.araddr;
                    rd_len       <= i_rd.arlen;
                    rd_beat      <= '0;
                end
            end else if (o_rd.rvalid && i_rd.rready) begin
                o_rd.rvalid <= 1'b0;
                rd_addr     <= rd_addr + 32'd4;
                rd_beat     <= rd_beat + 1'b1;
                if (o_rd.rlast) begin
                    rd_active <= 1'b0;
                end
            end else if (!o_rd.rvalid && (($random(seed) & 3) != 0)) begin
                o_rd.rvalid <= 1'b1;
                o_rd.rdata  <= read_word(rd_addr[ADDR_W-1:2]);
                o_rd.rlast  <= rd_beat == rd_len;
            end

            o_wr.awready <= !aw_got && (($random(seed) & 3) != 0);
            o_wr.wready  <= !w_got && (($random(seed) & 7) == 0);   // slow data channel
            if (i_wr.awvalid && o_wr.awready) begin
                aw_got       <= 1'b1;
                aw_addr      <= i_wr.awaddr;
                o_wr.awready <= 1'b0;
            end
            if (i_wr.wvalid && o_wr.wready) begin
                w_got       <= 1'b1;
                w_data      <= i_wr.wdata;
                w_strb      <= i_wr.wstrb;
                o_wr.wready <= 1'b0;
            end
            if (aw_got && w_got && !o_wr.bvalid) begin
                merged = read_word(aw_addr[ADDR_W-1:2]);
                for (int b = 0; b < STRB_W; b++) begin
                    if (w_strb[b]) begin
                        merged[8*b +: 8] = w_data[8*b +: 8];
                    end
                end
                mem[aw_addr[ADDR_W-1:2]] = merged;
                o_wr.bvalid <= 1'b1;
            end
            if (o_wr.bvalid && i_wr.bready) begin
                o_wr.bvalid <= 1'b0;
                aw_got      <= 1'b0;
                w_got       <= 1'b0;
            end
        end
    end

endmodule

// File: tb_cache_soc.sv
`timescale 1ns/1ps
module tb_cache_soc;
    import cache_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int CYCLES_PER_REQ = 200;
    localparam int IDLE_WAIT      = 100;

    typedef struct packed {
        logic [31:0] op;
        logic [31:0] cached;
        logic [31:0] addr;
        logic [31:0] size;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] refill;
    } trace_line_t;

    logic             clk;
    logic             rst;
    core_req_t        req;
    logic             req_valid;
    logic             req_ready;
    core_resp_t       resp;
    logic             resp_valid;
    logic             idle;
    axi_rd_req_t      axi_rd_req;
    axi_rd_resp_t     axi_rd_resp;
    axi_wr_req_t      axi_wr_req;
    axi_wr_resp_t     axi_wr_resp;

    trace_line_t       trace[$];
    int                n_lines;
    logic              trace_loaded;
    int                ar_count;
    logic [LEN_W-1:0]  last_arlen;
    logic [ADDR_W-1:0] last_araddr;
    int                wr_issued;
    int                b_count;
    int                stall_count;     // stores that met a full buffer
    int                idle_cycles;
    logic [31:0]       exp_aw_q[$];
    logic [35:0]       exp_w_q[$];      // strobes over lane data
    logic [31:0]       exp_aw;
    logic [35:0]       exp_w;

    cache_soc cache_soc_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_req        (req),
        .i_req_valid  (req_valid),
        .o_req_ready  (req_ready),
        .o_resp       (resp),
        .o_resp_valid (resp_valid),
        .o_idle       (idle),
        .o_axi_rd     (axi_rd_req),
        .i_axi_rd     (axi_rd_resp),
        .o_axi_wr     (axi_wr_req),
        .i_axi_wr     (axi_wr_resp)
    );

    axi_mem_model u_mem (
        .i_clk (clk),
        .i_rst (rst),
        .i_rd  (axi_rd_req),
        .o_rd  (axi_rd_resp),
        .i_wr  (axi_wr_req),
        .o_wr  (axi_wr_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%08h expected 0x%08h",
                                name, got, exp));
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          rc;
        string       line;
        trace_line_t t;
        logic [31:0] f_op;
        logic [31:0] f_cached;
        logic [31:0] f_addr;
        logic [31:0] f_size;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_refill;
        fd = $fopen("cache_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open cache_trace.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc   = $fgets(line, fd);
                if (rc > 0 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_cached, f_addr,
                                 f_size, f_wdata, f_rdata, f_refill);
                    if (rc == 7) begin
                        t = '{f_op, f_cached, f_addr, f_size, f_wdata, f_rdata, f_refill};
                        trace.push_back(t);
                    end else if (rc > 0) begin
                        abort_run({"malformed trace line: ", line});
                    end
                end
            end
            $fclose(fd);
            n_lines = trace.size();
        end
    endtask

    // byte lanes and strobes a store should show on the W channel
    task automatic queue_store(input trace_line_t t);
        logic [3:0]  strb;
        logic [31:0] lanes;
        for (int b = 0; b < 4; b++) begin
            case (t.size[1:0])
                SIZE_BYTE: begin
                    strb[b]          = (b == int'(t.addr[1:0]));
                    lanes[8*b +: 8]  = t.wdata[7:0];
                end
                SIZE_HALF: begin
                    strb[b]          = ((b / 2) == int'(t.addr[1]));
                    lanes[8*b +: 8]  = t.wdata[8*(b % 2) +: 8];
                end
                default: begin
                    strb[b]          = 1'b1;
                    lanes[8*b +: 8]  = t.wdata[8*b +: 8];
                end
            endcase
        end
        exp_aw_q.push_back({t.addr[31:2], 2'b00});
        exp_w_q.push_back({strb, lanes});
    endtask

    task automatic run_request(input trace_line_t t);
        int ar_before;
        int lat;
        ar_before = ar_count;
        if (t.op[1:0] == OP_WRITE) begin
            queue_store(t);
        end
        req.op     = mem_op_e'(t.op[1:0]);
        req.cached = t.cached[0];
        req.addr   = t.addr;
        req.size   = t.size[1:0];
        req.wdata  = t.wdata;
        req_valid  = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                          // transfer edge
        if (t.op[1:0] == OP_WRITE) begin
            wr_issued++;
        end
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!resp_valid) begin
            @(negedge clk);
            lat++;
        end
        compare_value("o_resp.rdata", resp.rdata, t.rdata);   // zero for non-reads
        compare_value("ar transfers", ar_count - ar_before, t.refill);
        if (t.refill[0]) begin
            compare_value("arlen", 32'(last_arlen), t.cached[0] ? 32'd3 : 32'd0);
            compare_value("araddr", last_araddr,
                          t.cached[0] ? {t.addr[31:4], 4'h0} : {t.addr[31:2], 2'b00});
        end
        if (t.op[1:0] == OP_WRITE && lat != 2) begin
            stall_count++;
        end else if (!t.refill[0]) begin
            compare_value("response latency", lat, 2);
        end
    endtask

    // bus activity seen at the falling edge, taken at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (axi_rd_req.arvalid && axi_rd_resp.arready) begin
                if (b_count != wr_issued) begin
                    abort_run("read address issued before earlier stores got a write response");
                end else begin
                    ar_count++;
                    last_arlen  = axi_rd_req.arlen;
                    last_araddr = axi_rd_req.araddr;
                end
            end
            if (axi_wr_req.awvalid && axi_wr_resp.awready) begin
                if (exp_aw_q.size() == 0) begin
                    abort_run("write address on the bus with no store pending");
                end else begin
                    exp_aw = exp_aw_q.pop_front();
                    compare_value("awaddr", axi_wr_req.awaddr, exp_aw);
                end
            end
            if (axi_wr_req.wvalid && axi_wr_resp.wready) begin
                if (exp_w_q.size() == 0) begin
                    abort_run("write data on the bus with no store pending");
                end else begin
                    exp_w = exp_w_q.pop_front();
                    compare_value("wstrb", {28'b0, axi_wr_req.wstrb}, {28'b0, exp_w[35:32]});
                    compare_value("wdata", axi_wr_req.wdata, exp_w[31:0]);
                    compare_value("wlast", 32'(axi_wr_req.wlast), 32'd1);
                end
            end
            if (axi_wr_resp.bvalid && axi_wr_req.bready) begin
                b_count++;
            end
        end
    end

    initial begin
        wait (trace_loaded);
        repeat (n_lines * CYCLES_PER_REQ) @(posedge clk);
        abort_run("timeout: the trace did not finish within its cycle budget");
    end

    initial begin
        rst          = 1'b1;
        req          = '0;
        req_valid    = 1'b0;
        trace_loaded = 1'b0;
        n_lines      = 0;
        ar_count     = 0;
        last_arlen   = '0;
        last_araddr  = '0;
        wr_issued    = 0;
        b_count      = 0;
        stall_count  = 0;
        idle_cycles  = 0;
        load_trace();
        if (n_lines == 0) begin
            abort_run("trace file holds no requests");
        end
        trace_loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // outputs held low by reset
        compare_value("o_req_ready", 32'(req_ready), 32'd0);
        compare_value("o_resp_valid", 32'(resp_valid), 32'd0);
        compare_value("arvalid", 32'(axi_rd_req.arvalid), 32'd0);
        compare_value("rready", 32'(axi_rd_req.rready), 32'd0);
        compare_value("awvalid", 32'(axi_wr_req.awvalid), 32'd0);
        compare_value("wvalid", 32'(axi_wr_req.wvalid), 32'd0);
        compare_value("bready", 32'(axi_wr_req.bready), 32'd0);
        foreach (trace[i]) begin
            run_request(trace[i]);
        end
        while (!idle && idle_cycles < IDLE_WAIT) begin
            @(negedge clk);
            idle_cycles++;
        end
        if (!idle) begin
            abort_run("o_idle stayed low after the last request");
        end else if (stall_count == 0) begin
            abort_run("the store burst never found the write buffer full");
        end else if (b_count != wr_issued || exp_w_q.size() != 0) begin
            abort_run("some stores never completed on the write bus");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: cache_trace.txt
# op cached addr size wdata exp_rdata refill (all hex)
# op 0 read 1 write 2 invalidate    size 0 byte 1 half 2 word
0 1 00001040 2 00000000 5a5a1040 1
0 1 00001044 2 00000000 5a5a1044 0
0 1 00001048 2 00000000 5a5a1048 0
0 1 0000104c 2 00000000 5a5a104c 0
1 1 00001041 0 000000ab 00000000 0
1 1 00001046 1 0000cdef 00000000 0
1 1 0000104b 0 00000077 00000000 0
0 1 00001040 2 00000000 5a5aab40 0
0 1 00001044 2 00000000 cdef1044 0
0 1 00001048 2 00000000 775a1048 0
1 0 00002000 2 12345678 00000000 0
0 0 00002000 2 00000000 12345678 1
2 1 00001040 2 00000000 00000000 0
0 1 0000104c 2 00000000 5a5a104c 1
0 1 00003044 2 00000000 5a5a3044 1
0 1 00001044 2 00000000 cdef1044 1
1 1 00004010 2 aabbccdd 00000000 0
0 1 00004010 2 00000000 aabbccdd 1
1 1 00005000 2 11110000 00000000 0
1 1 00005004 2 22220004 00000000 0
1 1 00005008 2 33330008 00000000 0
1 1 0000500c 2 4444000c 00000000 0
1 1 00005000 2 55550000 00000000 0
1 1 00005006 1 00009999 00000000 0
1 1 00005008 2 66660008 00000000 0
1 1 00005010 2 77770010 00000000 0
0 1 00005000 2 00000000 55550000 1
0 1 00005004 2 00000000 99990004 0
0 1 00005008 2 00000000 66660008 0
0 1 0000500c 2 00000000 4444000c 0
0 1 00005010 2 00000000 77770010 1

// File: all.f
cache_pkg.sv
core_req_port.sv
dcache_ctrl.sv
refill_engine.sv
write_buffer.sv
cache_soc.sv
axi_mem_model.sv
tb_cache_soc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_soc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TRACE     ?= cache_trace.txt
VFLAGS    ?= --binary --timing -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(TRACE)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
